//--- include/seg_settings.svh
`ifndef SEG_SETTINGS_SVH
`define SEG_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// display geometry and register map
//////////////////////////////////////////////////////////////////////

`define SEG_DIGITS 4       // common-anode digits on the board.
`define SEG_ADDR_W 4       // byte address bits of the register window.

`define SEG_REG_DATA   4'h0
`define SEG_REG_CTRL   4'h4   // bit 0 is hex mode, bit 1 selects the upper half.
`define SEG_REG_DIV    4'h8
`define SEG_REG_STATUS 4'hC   // read only, current digit index.

`define SEG_CTRL_RESET 2'b01  // {upper_half, hex_mode}.
`define SEG_DIV_RESET  16'd3

`endif

//--- rtl/seg_pkg.sv
`include "seg_settings.svh"

package seg_pkg;

    // master to slave side of the AXI4-Lite port.
    typedef struct packed {
        logic [`SEG_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [`SEG_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // slave to master side of the AXI4-Lite port.
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [31:0] value;
        logic        hex_mode;
        logic        upper_half;
        logic [15:0] div;        // scan period is div+1 cycles per digit.
    } disp_cfg_t;

    typedef struct packed {
        logic                           tick;
        logic [$clog2(`SEG_DIGITS)-1:0] index;
    } scan_t;

endpackage

//--- rtl/seg_ctrl.sv
`timescale 1ns/10ps
`include "seg_settings.svh"

module seg_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  seg_pkg::axil_req_t axil_req,
    output seg_pkg::axil_rsp_t axil_rsp,
    input  logic [1:0]         index,
    output seg_pkg::disp_cfg_t cfg,
    output logic               div_load
);
    import seg_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    disp_cfg_t   cfg_q;
    logic        aw_ready_q;
    logic        b_valid_q;
    logic [1:0]  b_resp_q;
    logic        ar_ready_q;
    logic        r_valid_q;
    logic [1:0]  r_resp_q;
    logic [31:0] r_data_q;
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_ok;
    logic [31:0] wr_merged;

    //////////////////////////////////////////////////////////////////////
    // register decode helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic reg_mapped(input logic [`SEG_ADDR_W-1:0] addr);
        return (addr == `SEG_REG_DATA) || (addr == `SEG_REG_CTRL) ||
               (addr == `SEG_REG_DIV)  || (addr == `SEG_REG_STATUS);
    endfunction

    // word seen by a read, unused bits are zero.
    function automatic logic [31:0] reg_value(input logic [`SEG_ADDR_W-1:0] addr,
                                              input disp_cfg_t               regs,
                                              input logic [1:0]              idx);
        logic [31:0] word;
        word = '0;
        case (addr)
            `SEG_REG_DATA:   word = regs.value;
            `SEG_REG_CTRL:   word = {30'b0, regs.upper_half, regs.hex_mode};
            `SEG_REG_DIV:    word = {16'b0, regs.div};
            `SEG_REG_STATUS: word = {30'b0, idx};
            default:         word = '0;
        endcase
        return word;
    endfunction

    function automatic logic [31:0] merge_strb(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign wr_fire   = aw_ready_q && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire   = ar_ready_q && axil_req.arvalid;
    assign wr_ok     = reg_mapped(axil_req.awaddr) && (axil_req.awaddr != `SEG_REG_STATUS);
    assign wr_merged = merge_strb(reg_value(axil_req.awaddr, cfg_q, index),
                                  axil_req.wdata, axil_req.wstrb);
    assign div_load  = wr_fire && wr_ok && (axil_req.awaddr == `SEG_REG_DIV); // restarts the scan count.

    //////////////////////////////////////////////////////////////////////
    // handshake state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            // accept only when address and data are both present and no response is held.
            aw_ready_q <= axil_req.awvalid && axil_req.wvalid && !aw_ready_q && !b_valid_q;
            ar_ready_q <= axil_req.arvalid && !ar_ready_q && !r_valid_q;
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (b_valid_q && axil_req.bready) begin
                b_valid_q <= 1'b0;
            end
            if (rd_fire) begin
                r_valid_q <= 1'b1;
            end else if (r_valid_q && axil_req.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            r_data_q <= reg_value(axil_req.araddr, cfg_q, index); // unmapped offsets give zero.
            r_resp_q <= reg_mapped(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q.value                          <= '0;
            {cfg_q.upper_half, cfg_q.hex_mode}   <= `SEG_CTRL_RESET;
            cfg_q.div                            <= `SEG_DIV_RESET;
        end else if (wr_fire && wr_ok) begin
            case (axil_req.awaddr)
                `SEG_REG_DATA: cfg_q.value <= wr_merged;
                `SEG_REG_CTRL: {cfg_q.upper_half, cfg_q.hex_mode} <= wr_merged[1:0];
                `SEG_REG_DIV:  cfg_q.div <= wr_merged[15:0];
                default:       cfg_q <= cfg_q;
            endcase
        end
    end

    assign axil_rsp.awready = aw_ready_q;
    assign axil_rsp.wready  = aw_ready_q;
    assign axil_rsp.bvalid  = b_valid_q;
    assign axil_rsp.bresp   = b_resp_q;
    assign axil_rsp.arready = ar_ready_q;
    assign axil_rsp.rvalid  = r_valid_q;
    assign axil_rsp.rdata   = r_data_q;
    assign axil_rsp.rresp   = r_resp_q;
    assign cfg              = cfg_q;

endmodule

//--- rtl/seg_scan.sv
`timescale 1ns/10ps

module seg_scan (
    input  logic               clk,
    input  logic               reset,
    input  seg_pkg::disp_cfg_t cfg,
    input  logic               div_load,
    output seg_pkg::scan_t     scan
);

    logic [15:0] count;
    logic        tick_q;
    logic [1:0]  index_q;

    // tick is registered, so index has already advanced while tick is high.
    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            tick_q  <= 1'b0;
            index_q <= '0;
        end else if (div_load) begin
            count  <= '0;                     // new period starts from zero.
            tick_q <= 1'b0;
        end else if (count >= cfg.div) begin
            count   <= '0;
            tick_q  <= 1'b1;
            index_q <= index_q + 2'd1;        // wraps after digit 3.
        end else begin
            count  <= count + 16'd1;
            tick_q <= 1'b0;
        end
    end

    assign scan.tick  = tick_q;
    assign scan.index = index_q;

endmodule

//--- rtl/seg_pattern.sv
`timescale 1ns/10ps
`include "seg_settings.svh"

module seg_pattern (
    input  logic                   clk,
    input  logic                   reset,
    input  seg_pkg::disp_cfg_t     cfg,
    input  seg_pkg::scan_t         scan,
    output logic [7:0]             seg,
    output logic [`SEG_DIGITS-1:0] an
);

    logic [15:0]            half;
    logic [3:0]             nibble;
    logic [7:0]             hex_seg;
    logic [7:0]             raw_seg;
    logic [7:0]             next_seg;
    logic [`SEG_DIGITS-1:0] next_an;

    //////////////////////////////////////////////////////////////////////
    // segment sources
    //////////////////////////////////////////////////////////////////////

    // bit 7 is dp, bits 6..0 are a..g, all active low.
    function automatic logic [7:0] hex_font(input logic [3:0] nib);
        logic [7:0] pat;
        case (nib)
            4'h0: pat = 8'b1000_0001;
            4'h1: pat = 8'b1100_1111;
            4'h2: pat = 8'b1001_0010;
            4'h3: pat = 8'b1000_0110;
            4'h4: pat = 8'b1100_1100;
            4'h5: pat = 8'b1010_0100;
            4'h6: pat = 8'b1010_0000;
            4'h7: pat = 8'b1000_1111;
            4'h8: pat = 8'b1000_0000;
            4'h9: pat = 8'b1000_0100;
            4'hA: pat = 8'b1000_1000;
            4'hB: pat = 8'b1110_0000; // lower case b.
            4'hC: pat = 8'b1011_0001;
            4'hD: pat = 8'b1100_0010; // lower case d.
            4'hE: pat = 8'b1011_0000;
            default: pat = 8'b1011_1000;
        endcase
        return pat;
    endfunction

    // each digit picks its eight bits from fixed spots of the data word.
    function automatic logic [7:0] raw_map(input logic [31:0] value,
                                           input logic [1:0]  digit);
        int k;
        k = int'(digit);
        return {value[24 + 2*k], value[k],        value[4 + 2*k],  value[16 + 2*k],
                value[25 + 2*k], value[17 + 2*k], value[5 + 2*k],  value[12 + k]};
    endfunction

    assign half     = cfg.upper_half ? cfg.value[31:16] : cfg.value[15:0];
    assign nibble   = half[4*scan.index +: 4];
    assign hex_seg  = hex_font(nibble);
    assign raw_seg  = raw_map(cfg.value, scan.index);
    assign next_seg = cfg.hex_mode ? hex_seg : raw_seg;

    always_comb begin
        next_an             = '1;
        next_an[scan.index] = 1'b0;           // one-cold select of the active digit.
    end

    //////////////////////////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            seg <= '1;
            an  <= '1;                        // all digits dark until the first tick.
        end else if (scan.tick) begin
            seg <= next_seg;
            an  <= next_an;
        end
    end

endmodule

//--- rtl/seg_display_top.sv
`timescale 1ns/10ps
`include "seg_settings.svh"

module seg_display_top (
    input  logic                   clk,
    input  logic                   reset,
    input  seg_pkg::axil_req_t     axil_req,
    output seg_pkg::axil_rsp_t     axil_rsp,
    output logic [7:0]             seg,
    output logic [`SEG_DIGITS-1:0] an
);
    import seg_pkg::*;

    disp_cfg_t cfg;
    scan_t     scan;
    logic      div_load;

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////

    seg_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .index    (scan.index),
        .cfg      (cfg),
        .div_load (div_load)
    );

    //////////////////////////////////////////////////////////////////////
    // display side
    //////////////////////////////////////////////////////////////////////

    seg_scan u_scan (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfg),
        .div_load (div_load),
        .scan     (scan)
    );

    // outputs follow the scan index one cycle after each tick.
    seg_pattern u_pattern (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg),
        .scan  (scan),
        .seg   (seg),
        .an    (an)
    );

endmodule

//--- tests/seg_display_chk.sv
`timescale 1ns/10ps
`include "seg_settings.svh"

module seg_display_chk (
    input logic                   clk,
    input logic                   reset,
    input seg_pkg::axil_req_t     axil_req,
    input seg_pkg::axil_rsp_t     axil_rsp,
    input logic [`SEG_DIGITS-1:0] an
);
    import seg_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // display and handshake properties
    ////////////////////////////////////////////////////////////////////

    an_one_cold: assert property (@(posedge clk) disable iff (reset)
        ($onehot(~an) || (an == '1)))
        else $error("anode vector %b is neither one-cold nor dark", an);

    // a held write response keeps its code.
    bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        (axil_rsp.bvalid && !axil_req.bready) |=> (axil_rsp.bvalid && $stable(axil_rsp.bresp)))
        else $error("write response dropped or changed before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        (axil_rsp.rvalid && !axil_req.rready) |=> (axil_rsp.rvalid && $stable(axil_rsp.rdata)))
        else $error("read data dropped or changed before rready");

    an_dark_after_reset: assert property (@(posedge clk)
        reset |=> (an == '1))
        else $error("digits lit right after reset");

endmodule

bind seg_display_top seg_display_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .an       (an)
);

//--- tests/seg_display_tb.sv
`timescale 1ns/10ps
`include "seg_settings.svh"

module seg_display_tb;
    import seg_pkg::*;

    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        reset;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [7:0]  seg;
    logic [3:0]  an;
    logic [3:0]  prev_an;
    logic [31:0] rng;
    logic [31:0] m_data;        // model copy of what the display should show.
    logic        m_hex;
    logic        m_upper;
    logic        check_en;
    int          errors;
    int          checks;
    int          tests;
    int          an_changes;
    int          digits_seen;

    seg_display_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .seg      (seg),
        .an       (an)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // returns {dp, a..g} active low for one digit.
    function automatic logic [7:0] expected_seg(input logic [31:0] data, input logic hex,
                                                input logic upper, input int digit);
        logic [6:0]  lit [16];
        logic [15:0] half;
        logic [3:0]  nib;
        int          src [8];
        logic [7:0]  pat;
        lit = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
                7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};
        src = '{12 + digit, 5 + 2*digit, 17 + 2*digit, 25 + 2*digit,
                16 + 2*digit, 4 + 2*digit, digit, 24 + 2*digit};
        if (hex) begin
            half = upper ? data[31:16] : data[15:0];
            nib  = half[4*digit +: 4];
            pat  = {1'b1, ~lit[nib]};
        end else begin
            for (int i = 0; i < 8; i++) begin
                pat[i] = data[src[i]];
            end
        end
        return pat;
    endfunction

    function automatic int digit_of(input logic [3:0] anodes);
        int d;
        d = 0;
        for (int i = 0; i < 4; i++) begin
            if (!anodes[i]) begin
                d = i;
            end
        end
        return d;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s at t=%0t", what, $time);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // samples at the falling edge, where every output has settled.
    always @(negedge clk) begin
        if (!reset) begin
            if (an !== prev_an) begin
                an_changes++;
                if (check_en && $onehot(~an)) begin
                    check("seg", {24'h0, seg},
                          {24'h0, expected_seg(m_data, m_hex, m_upper, digit_of(an))});
                    digits_seen++;
                end
            end
            prev_an = an;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite master tasks
    //////////////////////////////////////////////////////////////////////

    task automatic send_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.wvalid  <= 1'b1;
    endtask

    task automatic wait_accept_write();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_timeout("awready");
        end while (!axil_rsp.awready);
        check("wready", {31'h0, axil_rsp.wready}, 32'h1);
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
    endtask

    task automatic wait_bresp(output logic [1:0] resp);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_timeout("bvalid");
        end while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        send_write(addr, data, strb);
        wait_accept_write();
        wait_bresp(resp);
        @(posedge clk);                       // bready is high, response completes here.
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_timeout("arready");
        end while (!axil_rsp.arready);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_timeout("rvalid");
        end while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
    endtask

    task automatic write_ok(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, 4'hF, resp);
        check("bresp", {30'h0, resp}, 32'h0);
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp,
                               input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check("rdata", data, exp);
        check("rresp", {30'h0, resp}, {30'h0, exp_resp});
    endtask

    task automatic wait_an_changes(input int count);
        int start;
        int n;
        start = an_changes;
        n = 0;
        while (an_changes < start + count) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) fail_timeout("an to change");
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // display tests
    //////////////////////////////////////////////////////////////////////

    task automatic show_word(input logic [31:0] word, input logic hex, input logic upper);
        int start;
        check_en = 1'b0;
        write_ok(`SEG_REG_DATA, word);
        write_ok(`SEG_REG_CTRL, {30'h0, upper, hex});
        m_data  = word;
        m_hex   = hex;
        m_upper = upper;
        wait_an_changes(2);                   // let the new setting reach the outputs.
        start    = digits_seen;
        check_en = 1'b1;
        wait_an_changes(8);
        check_en = 1'b0;
        if (digits_seen - start < 8) begin
            errors++;
            $display("too few digits were compared for word %h", word);
        end
    endtask

    task automatic scan_rate(input logic [15:0] div);
        logic [3:0] last;
        int         n;
        int         d;
        write_ok(`SEG_REG_DIV, {16'h0, div});
        for (int i = 0; i < 9; i++) begin
            last = an;
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT) fail_timeout("scan step");
            end while (an === last);
            // the first change may still carry the old period.
            if (i > 0) begin
                check("scan_period", n, {16'h0, div} + 32'd1);
                check("digit_order", digit_of(an), (d + 1) % 4);
            end
            d = digit_of(an);
        end
    endtask

    task automatic back_pressure();
        logic [1:0]  resp;
        logic [1:0]  first;
        logic [31:0] data;
        @(posedge clk);
        axil_req.bready <= 1'b0;
        send_write(`SEG_REG_DATA, 32'h0BAD_F00D, 4'hF);
        wait_accept_write();
        wait_bresp(first);
        send_write(`SEG_REG_CTRL, 32'h3, 4'hF);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check("bvalid", {31'h0, axil_rsp.bvalid}, 32'h1);
            check("bresp", {30'h0, axil_rsp.bresp}, {30'h0, first});
            check("awready", {31'h0, axil_rsp.awready}, 32'h0);
            check("wready", {31'h0, axil_rsp.wready}, 32'h0);
        end
        @(posedge clk);
        axil_req.bready <= 1'b1;
        wait_accept_write();
        wait_bresp(resp);
        @(posedge clk);
        check("bresp", {30'h0, first}, 32'h0);
        check("bresp", {30'h0, resp}, 32'h0);
        read_expect(`SEG_REG_DATA, 32'h0BAD_F00D, 2'b00);
        read_expect(`SEG_REG_CTRL, 32'h3, 2'b00);

        // a held read response keeps its data until rready.
        @(posedge clk);
        axil_req.rready <= 1'b0;
        axi_read(`SEG_REG_DATA, data, resp);
        check("rdata", data, 32'h0BAD_F00D);
        check("rresp", {30'h0, resp}, 32'h0);
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check("rvalid", {31'h0, axil_rsp.rvalid}, 32'h1);
            check("rdata", axil_rsp.rdata, 32'h0BAD_F00D);
        end
        @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check("rvalid", {31'h0, axil_rsp.rvalid}, 32'h0);
    endtask

    initial begin
        logic [1:0]  resp;
        logic [31:0] word;
        axil_req    = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        reset       = 1'b1;
        prev_an     = '1;
        rng         = 32'h22fd625d;
        check_en    = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        an_changes  = 0;
        digits_seen = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        write_ok(`SEG_REG_DATA, 32'h1234_5678);
        axi_write(`SEG_REG_DATA, 32'hAABB_CCDD, 4'b0101, resp);
        check("bresp", {30'h0, resp}, 32'h0);
        read_expect(`SEG_REG_DATA, 32'h12BB_56DD, 2'b00);
        axi_write(`SEG_REG_CTRL, 32'hFFFF_FFFF, 4'b0001, resp);
        check("bresp", {30'h0, resp}, 32'h0);
        read_expect(`SEG_REG_CTRL, 32'h3, 2'b00);
        axi_write(`SEG_REG_DIV, 32'h00AB_CDEF, 4'b0011, resp);
        check("bresp", {30'h0, resp}, 32'h0);
        read_expect(`SEG_REG_DIV, 32'h0000_CDEF, 2'b00);
        write_ok(`SEG_REG_DIV, 32'h2);
        finish_test("register access");

        axi_write(`SEG_REG_STATUS, 32'h0, 4'hF, resp);
        check("bresp", {30'h0, resp}, 32'h2);
        axi_write(4'hE, 32'h0, 4'hF, resp);
        check("bresp", {30'h0, resp}, 32'h2);
        read_expect(`SEG_REG_DATA, 32'h12BB_56DD, 2'b00);
        read_expect(`SEG_REG_CTRL, 32'h3, 2'b00);
        read_expect(`SEG_REG_DIV, 32'h2, 2'b00);
        read_expect(4'h2, 32'h0, 2'b10);
        finish_test("error responses");

        for (int i = 0; i < 3; i++) begin
            rng  = xorshift32(rng);
            word = rng;
            show_word(word, 1'b1, 1'b0);
            show_word(word, 1'b1, 1'b1);
        end
        finish_test("hex mode");

        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            show_word(rng, 1'b0, 1'b0);
        end
        finish_test("raw mode");

        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            scan_rate(16'(rng % 32'd21));
        end
        scan_rate(16'd0);
        finish_test("scan rate");

        back_pressure();
        finish_test("back pressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
rtl/seg_pkg.sv
rtl/seg_ctrl.sv
rtl/seg_scan.sv
rtl/seg_pattern.sv
rtl/seg_display_top.sv
tests/seg_display_chk.sv
tests/seg_display_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the seven-segment controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -f sim.log build.log

verilator --binary --timing --assert -f list.f \
    --top-module seg_display_tb -o seg_sim > build.log 2>&1 &&
    ./obj_dir/seg_sim > sim.log 2>&1 ||
    { cat build.log >> sim.log; echo "SIMULATION FAILED" >> sim.log; }

cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; } ||
    { echo "run passed"; exit 0; }
